/* source/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// first fetch address after reset
`define RESET_PC 32'h1c00_0000
`define NUM_REGS 32

// opcode field values, width follows the format
`define OP_ADD_W   17'h00020
`define OP_SUB_W   17'h00022
`define OP_AND     17'h00029
`define OP_OR      17'h0002a
`define OP_XOR     17'h0002b
`define OP_ADDI_W  10'h00a
`define OP_LD_W    10'h0a2
`define OP_ST_W    10'h0a6
`define OP_BEQ     6'h16
`define OP_BNE     6'h17
`define OP_LU12I_W 7'h0a

`endif

/* source/isa_pkg.sv */
package isa_pkg;

    typedef struct packed {
        logic [16:0] opcode17;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_r3_t;

    typedef struct packed {
        logic [9:0]  opcode10;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri12_t;

    typedef struct packed {
        logic [5:0]  opcode6;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri16_t;

    typedef struct packed {
        logic [6:0]  opcode7;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_ri20_t;

    // one instruction word, four field layouts
    typedef union packed {
        fmt_r3_t   r3;
        fmt_ri12_t ri12;
        fmt_ri16_t ri16;
        fmt_ri20_t ri20;
    } instr_word_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b,
        alu_beq,
        alu_bne,
        alu_none
    } alu_op_e;

    // shared by execute and the forwarding path
    function automatic logic [31:0] alu_eval(alu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        case (op)
            alu_add:    r = a + b;
            alu_sub:    r = a - b;
            alu_and:    r = a & b;
            alu_or:     r = a | b;
            alu_xor:    r = a ^ b;
            alu_pass_b: r = b;
            default:    r = 32'b0;
        endcase
        return r;
    endfunction

endpackage

/* source/pipe_pkg.sv */
package pipe_pkg;
    import isa_pkg::*;

    // decode to execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [31:0] store_data;
        logic [4:0]  dest;
        logic        reg_we;
        logic        is_load;
        logic        is_store;
        logic [31:0] branch_offset;
    } dec_exe_t;

    // execute to result
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        reg_we;
        logic        is_load;
        logic [31:0] result;
    } exe_res_t;

endpackage

/* source/pipe_if.sv */
`timescale 1ns/1ps

interface dec_exe_if import pipe_pkg::*;;
    dec_exe_t rec;

    modport producer (output rec);
    modport consumer (input rec);
    modport monitor  (input rec);
endinterface

interface exe_res_if import pipe_pkg::*;;
    exe_res_t rec;

    modport producer (output rec);
    modport consumer (input rec);
    modport monitor  (input rec);
endinterface

/* source/fetch_stage.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_front,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic [31:0] fetch_pc,
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr
);

    logic [31:0] pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `RESET_PC;
            fetch_pc <= `RESET_PC;
        end else begin
            if (redirect)
                pc <= redirect_pc;
            else if (!stall_front)
                pc <= pc + 32'd4;
            // follows the word coming back from the SRAM
            if (!stall_front)
                fetch_pc <= pc;
        end
    end

    assign inst_sram_en   = 1'b1;
    assign inst_sram_we   = 4'b0;
    assign inst_sram_addr = pc;

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall_front,
    input  logic        flush_front,
    input  logic [31:0] fetch_pc,
    input  logic [31:0] inst_word,
    input  logic        fwd_a_sel,
    input  logic        fwd_b_sel,
    input  logic [31:0] fwd_a,
    input  logic [31:0] fwd_b,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [4:0]  rj,
    output logic [4:0]  rk_rd,
    dec_exe_if.producer dx
);

    logic [31:0] regs [`NUM_REGS];
    logic [31:0] held_word;
    logic        use_held;
    logic        kill;
    instr_word_u iw;
    alu_op_e     op;
    logic [31:0] imm;
    logic [31:0] boff;
    logic        use_imm;
    logic        reg_we;
    logic        is_load;
    logic        is_store;
    logic        second_is_rd;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;

    // the SRAM moves on during a stall, so replay the saved word
    assign iw = use_held ? held_word : inst_word;

    always_ff @(posedge clk) begin
        held_word <= iw;
        if (reset) begin
            use_held <= 1'b0;
            kill     <= 1'b1;
        end else begin
            use_held <= stall_front;
            // word already in flight behind a taken branch
            kill     <= flush_front;
        end
    end

    always_comb begin
        op           = alu_none;
        imm          = {{20{iw.ri12.si12[11]}}, iw.ri12.si12};
        boff         = {{14{iw.ri16.offs16[15]}}, iw.ri16.offs16, 2'b00};
        use_imm      = 1'b0;
        reg_we       = 1'b0;
        is_load      = 1'b0;
        is_store     = 1'b0;
        second_is_rd = 1'b0;
        if (iw.r3.opcode17 == `OP_ADD_W) begin
            op     = alu_add;
            reg_we = 1'b1;
        end else if (iw.r3.opcode17 == `OP_SUB_W) begin
            op     = alu_sub;
            reg_we = 1'b1;
        end else if (iw.r3.opcode17 == `OP_AND) begin
            op     = alu_and;
            reg_we = 1'b1;
        end else if (iw.r3.opcode17 == `OP_OR) begin
            op     = alu_or;
            reg_we = 1'b1;
        end else if (iw.r3.opcode17 == `OP_XOR) begin
            op     = alu_xor;
            reg_we = 1'b1;
        end else if (iw.ri12.opcode10 == `OP_ADDI_W) begin
            op      = alu_add;
            use_imm = 1'b1;
            reg_we  = 1'b1;
        end else if (iw.ri12.opcode10 == `OP_LD_W) begin
            op      = alu_add;
            use_imm = 1'b1;
            reg_we  = 1'b1;
            is_load = 1'b1;
        end else if (iw.ri12.opcode10 == `OP_ST_W) begin
            op           = alu_add;
            use_imm      = 1'b1;
            is_store     = 1'b1;
            second_is_rd = 1'b1;
        end else if (iw.ri16.opcode6 == `OP_BEQ) begin
            op           = alu_beq;
            second_is_rd = 1'b1;
        end else if (iw.ri16.opcode6 == `OP_BNE) begin
            op           = alu_bne;
            second_is_rd = 1'b1;
        end else if (iw.ri20.opcode7 == `OP_LU12I_W) begin
            op      = alu_pass_b;
            imm     = {iw.ri20.si20, 12'b0};
            use_imm = 1'b1;
            reg_we  = 1'b1;
        end
    end

    assign rj    = iw.r3.rj;
    assign rk_rd = second_is_rd ? iw.r3.rd : iw.r3.rk;

    // r0 reads as zero
    assign opnd_a = fwd_a_sel ? fwd_a : (rj == 5'd0 ? 32'b0 : regs[rj]);
    assign opnd_b = fwd_b_sel ? fwd_b : (rk_rd == 5'd0 ? 32'b0 : regs[rk_rd]);

    always_ff @(posedge clk) begin
        if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        dx.rec.pc            <= fetch_pc;
        dx.rec.alu_op        <= op;
        dx.rec.src_a         <= opnd_a;
        dx.rec.src_b         <= use_imm ? imm : opnd_b;
        dx.rec.store_data    <= opnd_b;
        dx.rec.dest          <= iw.r3.rd;
        dx.rec.reg_we        <= reg_we;
        dx.rec.is_load       <= is_load;
        dx.rec.is_store      <= is_store;
        dx.rec.branch_offset <= boff;
        if (reset)
            dx.rec.valid <= 1'b0;
        else
            dx.rec.valid <= ~kill & ~stall_front & ~flush_front;
    end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bubble,
    dec_exe_if.consumer dx,
    exe_res_if.producer xr,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata
);

    logic        bubble_q;
    logic        v;
    logic [31:0] result;
    logic        equal;

    always_ff @(posedge clk) begin
        if (reset)
            bubble_q <= 1'b0;
        else
            bubble_q <= bubble;
    end

    assign v      = dx.rec.valid & ~bubble_q;
    assign result = alu_eval(dx.rec.alu_op, dx.rec.src_a, dx.rec.src_b);
    assign equal  = dx.rec.src_a == dx.rec.src_b;

    // branches resolve here
    assign redirect    = v & ((dx.rec.alu_op == alu_beq && equal) ||
                              (dx.rec.alu_op == alu_bne && !equal));
    assign redirect_pc = dx.rec.pc + dx.rec.branch_offset;

    // address comes straight from the adder
    assign data_sram_en    = v & (dx.rec.is_load | dx.rec.is_store);
    assign data_sram_we    = (v & dx.rec.is_store) ? 4'hf : 4'h0;
    assign data_sram_addr  = result;
    assign data_sram_wdata = dx.rec.store_data;

    always_ff @(posedge clk) begin
        xr.rec.pc      <= dx.rec.pc;
        xr.rec.dest    <= dx.rec.dest;
        xr.rec.reg_we  <= dx.rec.reg_we;
        xr.rec.is_load <= dx.rec.is_load;
        xr.rec.result  <= result;
        if (reset)
            xr.rec.valid <= 1'b0;
        else
            xr.rec.valid <= v;
    end

endmodule

/* source/result_stage.sv */
`timescale 1ns/1ps

module result_stage (
    exe_res_if.consumer xr,
    input  logic [31:0] data_sram_rdata,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    // load data lands one cycle after the request
    assign wr_data = xr.rec.is_load ? data_sram_rdata : xr.rec.result;
    assign wr_addr = xr.rec.dest;
    // r0 stays zero
    assign wr_en   = xr.rec.valid & xr.rec.reg_we & (xr.rec.dest != 5'd0);

    assign debug_wb_pc       = xr.rec.pc;
    assign debug_wb_rf_we    = {4{wr_en}};
    assign debug_wb_rf_wnum  = wr_addr;
    assign debug_wb_rf_wdata = wr_data;

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
    import isa_pkg::*;
(
    input  logic [4:0]  rj,
    input  logic [4:0]  rk_rd,
    dec_exe_if.monitor  dx,
    exe_res_if.monitor  xr,
    input  logic [31:0] wr_data,
    input  logic        redirect,
    output logic        stall_front,
    output logic        flush_front,
    output logic        bubble,
    output logic        fwd_a_sel,
    output logic        fwd_b_sel,
    output logic [31:0] fwd_a,
    output logic [31:0] fwd_b
);

    logic        ex_hit_a;
    logic        ex_hit_b;
    logic        res_hit_a;
    logic        res_hit_b;
    logic        load_use;
    logic [31:0] ex_value;

    assign ex_hit_a  = dx.rec.valid & dx.rec.reg_we & (dx.rec.dest == rj) & (rj != 5'd0);
    assign ex_hit_b  = dx.rec.valid & dx.rec.reg_we & (dx.rec.dest == rk_rd) & (rk_rd != 5'd0);
    assign res_hit_a = xr.rec.valid & xr.rec.reg_we & (xr.rec.dest == rj) & (rj != 5'd0);
    assign res_hit_b = xr.rec.valid & xr.rec.reg_we & (xr.rec.dest == rk_rd) & (rk_rd != 5'd0);

    // the instruction in execute, ahead of its register stage
    assign ex_value = alu_eval(dx.rec.alu_op, dx.rec.src_a, dx.rec.src_b);

    // load data is not back yet, wait one cycle
    assign load_use    = dx.rec.is_load & (ex_hit_a | ex_hit_b);
    assign stall_front = load_use;
    assign flush_front = redirect;
    assign bubble      = load_use | redirect;

    assign fwd_a_sel = ex_hit_a | res_hit_a;
    assign fwd_b_sel = ex_hit_b | res_hit_b;
    assign fwd_a     = ex_hit_a ? ex_value : wr_data;
    assign fwd_b     = ex_hit_b ? ex_value : wr_data;

endmodule

/* source/mini_core.sv */
`timescale 1ns/1ps

module mini_core (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic        stall_front;
    logic        flush_front;
    logic        bubble;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [31:0] fetch_pc;
    logic        fwd_a_sel;
    logic        fwd_b_sel;
    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic [4:0]  rj;
    logic [4:0]  rk_rd;

    dec_exe_if dx_bus ();
    exe_res_if xr_bus ();

    // instruction port is read only
    assign inst_sram_wdata = 32'b0;

    fetch_stage u_fetch (
        .clk            (clk),
        .reset          (reset),
        .stall_front    (stall_front),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .fetch_pc       (fetch_pc),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_we   (inst_sram_we),
        .inst_sram_addr (inst_sram_addr)
    );

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .stall_front (stall_front),
        .flush_front (flush_front),
        .fetch_pc    (fetch_pc),
        .inst_word   (inst_sram_rdata),
        .fwd_a_sel   (fwd_a_sel),
        .fwd_b_sel   (fwd_b_sel),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rj          (rj),
        .rk_rd       (rk_rd),
        .dx          (dx_bus.producer)
    );

    execute_stage u_execute (
        .clk             (clk),
        .reset           (reset),
        .bubble          (bubble),
        .dx              (dx_bus.consumer),
        .xr              (xr_bus.producer),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    result_stage u_result (
        .xr                (xr_bus.consumer),
        .data_sram_rdata   (data_sram_rdata),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    hazard_unit u_hazard (
        .rj          (rj),
        .rk_rd       (rk_rd),
        .dx          (dx_bus.monitor),
        .xr          (xr_bus.monitor),
        .wr_data     (wr_data),
        .redirect    (redirect),
        .stall_front (stall_front),
        .flush_front (flush_front),
        .bubble      (bubble),
        .fwd_a_sel   (fwd_a_sel),
        .fwd_b_sel   (fwd_b_sel),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

endmodule

/* bench/tb_mem.sv */
`timescale 1ns/1ps

module tb_mem (
    input  logic        clk,
    input  logic        inst_en,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst_rdata,
    input  logic        data_en,
    input  logic [3:0]  data_we,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic [31:0] data_rdata
);

    // contents are loaded by the testbench before reset ends
    logic [31:0] rom [256];
    logic [31:0] ram [64];
    logic [31:0] inst_q = 32'h0;
    logic [31:0] data_q = 32'h0;

    assign inst_rdata = inst_q;
    assign data_rdata = data_q;

    always @(posedge clk) begin
        if (inst_en)
            inst_q <= rom[inst_addr[9:2]];
    end

    // read returns the old word, byte enables on write
    always @(posedge clk) begin
        if (data_en) begin
            data_q <= ram[data_addr[7:2]];
            if (data_we[0])
                ram[data_addr[7:2]][7:0] <= data_wdata[7:0];
            if (data_we[1])
                ram[data_addr[7:2]][15:8] <= data_wdata[15:8];
            if (data_we[2])
                ram[data_addr[7:2]][23:16] <= data_wdata[23:16];
            if (data_we[3])
                ram[data_addr[7:2]][31:24] <= data_wdata[31:24];
        end
    end

endmodule

/* bench/core_tb.sv */
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb
    import isa_pkg::*;
();

    localparam int PROG_LEN = 120;
    localparam int TIMEOUT  = PROG_LEN * 3 + 60;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] prog [128];
    logic [31:0] mregs [`NUM_REGS];
    logic [31:0] mmem [64];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] seed;
    int          value_errors;
    int          other_errors;
    int          cycles;

    mini_core DUT (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_mem mem (
        .clk        (clk),
        .inst_en    (inst_sram_en),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_en    (data_sram_en),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] draw(input logic [31:0] n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return (seed >> 8) % n;
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(draw(8));
    endfunction

    // distinct start value for every data word
    function automatic logic [31:0] mem_fill(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
    endfunction

    task automatic gen_program();
        int          idx;
        int          kind;
        int          offs;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [11:0] off12;
        logic [16:0] op17;
        for (int i = 0; i < 128; i++)
            prog[7'(i)] = 32'h0;
        // r1..r7 get known values first
        for (int r = 1; r < 8; r++)
            prog[7'(r - 1)] = {`OP_ADDI_W, 12'(draw(32'h1000)), 5'd0, 5'(r)};
        idx = 7;
        while (idx < PROG_LEN) begin
            kind  = int'(draw(8));
            ra    = pick_reg();
            rb    = pick_reg();
            rc    = pick_reg();
            off12 = 12'(draw(64) << 2);
            case (kind)
                0, 1: begin
                    case (draw(5))
                        0: op17 = `OP_ADD_W;
                        1: op17 = `OP_SUB_W;
                        2: op17 = `OP_AND;
                        3: op17 = `OP_OR;
                        default: op17 = `OP_XOR;
                    endcase
                    prog[7'(idx)] = {op17, rc, rb, ra};
                    idx++;
                end
                2: begin
                    prog[7'(idx)] = {`OP_ADDI_W, 12'(draw(32'h1000)), rb, ra};
                    idx++;
                end
                3: begin
                    prog[7'(idx)] = {`OP_LU12I_W, 20'(draw(32'h10_0000)), ra};
                    idx++;
                end
                4: begin
                    // store, load back, use the loaded value at once
                    if (idx + 3 <= PROG_LEN) begin
                        prog[7'(idx)]     = {`OP_ST_W, off12, 5'd0, rb};
                        prog[7'(idx + 1)] = {`OP_LD_W, off12, 5'd0, ra};
                        prog[7'(idx + 2)] = {`OP_ADD_W, rb, ra, rc};
                        idx += 3;
                    end
                end
                5: begin
                    prog[7'(idx)] = {`OP_LD_W, off12, 5'd0, ra};
                    idx++;
                end
                6: begin
                    prog[7'(idx)] = {`OP_ST_W, off12, 5'd0, rb};
                    idx++;
                end
                default: begin
                    offs = 2 + int'(draw(2));
                    if (idx + offs <= PROG_LEN) begin
                        if (draw(4) == 0)
                            rb = ra;
                        prog[7'(idx)] = {(draw(2) == 0) ? `OP_BEQ : `OP_BNE,
                                         16'(offs), ra, rb};
                        idx++;
                    end
                end
            endcase
        end
        // beq r0, r0, 0 parks the core at the end
        prog[7'(PROG_LEN)] = {`OP_BEQ, 16'h0, 5'd0, 5'd0};
    endtask

    // in-order interpreter that fills the expected trace and store queues
    task automatic run_model();
        instr_word_u iw;
        int          idx;
        int          next;
        int          steps;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] val;
        logic        wr;
        for (int r = 0; r < `NUM_REGS; r++)
            mregs[5'(r)] = 32'h0;
        for (int w = 0; w < 64; w++)
            mmem[6'(w)] = mem_fill(32'(w * 4));
        idx   = 0;
        steps = 0;
        while (idx != PROG_LEN && steps < 1000) begin
            iw    = prog[7'(idx)];
            a     = mregs[iw.r3.rj];
            b     = mregs[iw.r3.rk];
            imm   = {{20{iw.ri12.si12[11]}}, iw.ri12.si12};
            val   = 32'h0;
            wr    = 1'b1;
            next  = idx + 1;
            steps++;
            if (iw.r3.opcode17 == `OP_ADD_W)
                val = a + b;
            else if (iw.r3.opcode17 == `OP_SUB_W)
                val = a - b;
            else if (iw.r3.opcode17 == `OP_AND)
                val = a & b;
            else if (iw.r3.opcode17 == `OP_OR)
                val = a | b;
            else if (iw.r3.opcode17 == `OP_XOR)
                val = a ^ b;
            else if (iw.ri12.opcode10 == `OP_ADDI_W)
                val = a + imm;
            else if (iw.ri12.opcode10 == `OP_LD_W)
                val = mmem[6'((a + imm) >> 2)];
            else if (iw.ri12.opcode10 == `OP_ST_W) begin
                wr = 1'b0;
                mmem[6'((a + imm) >> 2)] = mregs[iw.r3.rd];
                exp_st_addr.push_back(a + imm);
                exp_st_data.push_back(mregs[iw.r3.rd]);
            end else if (iw.ri16.opcode6 == `OP_BEQ || iw.ri16.opcode6 == `OP_BNE) begin
                wr = 1'b0;
                if ((a == mregs[iw.r3.rd]) == (iw.ri16.opcode6 == `OP_BEQ))
                    next = idx + int'($signed(iw.ri16.offs16));
            end else
                val = {iw.ri20.si20, 12'h0};
            if (wr && iw.r3.rd != 5'd0) begin
                mregs[iw.r3.rd] = val;
                exp_pc.push_back(`RESET_PC + 32'(idx * 4));
                exp_num.push_back(iw.r3.rd);
                exp_data.push_back(val);
            end
            idx = next;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_idle(input string name);
        check_word({name, "_inst_addr"}, `RESET_PC, inst_sram_addr);
        check_word({name, "_data_en"}, 32'h0, {31'b0, data_sram_en});
        check_word({name, "_rf_we"}, 32'h0, {28'b0, debug_wb_rf_we});
    endtask

    task automatic report_counts();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    // instruction port, trace and store checks
    always @(negedge clk) begin
        // instruction port only ever reads
        check_word("inst_en", 32'h1, {31'b0, inst_sram_en});
        check_word("inst_we", 32'h0, {28'b0, inst_sram_we});
        check_word("inst_wdata", 32'h0, inst_sram_wdata);
        if (debug_wb_rf_we != 4'h0) begin
            assert (debug_wb_rf_we == 4'hf && debug_wb_rf_wnum != 5'd0) else begin
                $display("trace write with rf_we %h to register %0d",
                         debug_wb_rf_we, debug_wb_rf_wnum);
                other_errors++;
            end
            assert (exp_pc.size() != 0) else begin
                $display("trace write at pc %h after the program ended", debug_wb_pc);
                other_errors++;
            end
            if (exp_pc.size() != 0) begin
                check_word("trace_pc", exp_pc.pop_front(), debug_wb_pc);
                check_word("trace_wnum", {27'b0, exp_num.pop_front()},
                           {27'b0, debug_wb_rf_wnum});
                check_word("trace_wdata", exp_data.pop_front(), debug_wb_rf_wdata);
            end
        end
        if (data_sram_we != 4'h0) begin
            check_word("store_we", 32'hf, {28'b0, data_sram_we});
            check_word("store_en", 32'h1, {31'b0, data_sram_en});
            assert (exp_st_addr.size() != 0) else begin
                $display("store to %h that the program does not make", data_sram_addr);
                other_errors++;
            end
            if (exp_st_addr.size() != 0) begin
                check_word("store_addr", exp_st_addr.pop_front(), data_sram_addr);
                check_word("store_data", exp_st_data.pop_front(), data_sram_wdata);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset)
            cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            other_errors++;
            $display("timed out after %0d cycles with %0d trace writes still due",
                     cycles, exp_pc.size());
            report_counts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        seed         = 32'hafa2_221c;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        gen_program();
        for (int i = 0; i < 256; i++)
            mem.rom[8'(i)] = (i < 128) ? prog[7'(i)] : 32'h0;
        for (int w = 0; w < 64; w++)
            mem.ram[6'(w)] = mem_fill(32'(w * 4));
        run_model();
        repeat (10) begin
            @(negedge clk);
            check_idle("reset");
        end
        reset = 1'b0;
        #10;
        check_idle("after_reset");
        while (exp_pc.size() != 0 || exp_st_addr.size() != 0)
            @(negedge clk);
        // a few more cycles to catch stray writes
        repeat (8) @(negedge clk);
        report_counts();
        if (value_errors + other_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/hazard_unit.sv
source/mini_core.sv
bench/tb_mem.sv
bench/core_tb.sv

/* Makefile */
SIM      = verilator
TOP      = core_tb
FILELIST = verilog.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
OBJ_DIR  = obj_dir
SOURCES  = $(wildcard source/*.sv source/*.svh bench/*.sv)
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR)
